/* irq_trace.f */
+incdir+source
source/trace_pkg.sv
source/sync_fifo.sv
source/trace_timestamp.sv
source/cobs_frame_encoder.sv
source/uart_tx.sv
source/irq_trace_top.sv
verification/irq_trace_props.sv
verification/irq_trace_tb.sv

/* verification/irq_trace_tb.sv */
// irq_trace_tb: table-driven testbench with serial receiver, COBS decoder and record checker
`timescale 1ns/1ps
`include "trace_params.svh"

module irq_trace_tb;
  import trace_pkg::*;

  localparam int clk_period = 40;
  localparam int frame_cycles = 7 * 10 * `TRACE_BAUD_DIV;
  localparam int table_len = 6 + `TRACE_EVT_DEPTH + 11;
  localparam int rand_len = 16;
  localparam longint watchdog_ns =
    longint'(table_len + rand_len) * frame_cycles * 2 * clk_period;

  typedef struct packed {
    logic        valid;
    logic [7:0]  id;
    logic [7:0]  prio;
    logic        tail_chain;
    logic        align_ts;
    logic [15:0] gap;
  } stim_t;

  logic       clk_i;
  logic       reset_i;
  logic       event_valid_i;
  irq_event_t event_i;
  logic       tx_o;
  logic       queue_full_o;

  stim_t       stim_table[table_len];
  logic [39:0] exp_q[$];
  byte_t       rx_frame[$];
  int          cycle_cnt;
  int          checks;
  int          errors;
  int          frames;
  int          rx_count;
  int          offered;
  int          accepted;
  int          dropped;
  logic        saw_full;
  logic [31:0] lcg_state;

  irq_trace_top uut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .event_valid_i(event_valid_i),
    .event_i      (event_i),
    .tx_o         (tx_o),
    .queue_full_o (queue_full_o)
  );

  bind irq_trace_top irq_trace_props props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .tx_i        (tx_o),
    .queue_full_i(queue_full_o)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  // rising edges since reset release give the expected timestamp
  always @(posedge clk_i) begin
    if (reset_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %s: got 0x%0h expected 0x%0h at %0t", name, actual, expected, $time);
    end
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic stim_t make_entry(input logic valid, input logic [7:0] id,
                                       input logic [7:0] prio, input logic tail,
                                       input logic align, input int gap);
    stim_t s;
    s.valid      = valid;
    s.id         = id;
    s.prio       = prio;
    s.tail_chain = tail;
    s.align_ts   = align;
    s.gap        = 16'(gap);
    return s;
  endfunction

  // called on a falling edge so the event is sampled at the next rising edge
  task automatic apply_event(input stim_t s);
    logic [15:0] ts;
    if (s.align_ts) begin
      while (((cycle_cnt / `TRACE_TICK_DIV) % 256) != 0) begin
        @(negedge clk_i);
      end
    end
    if (s.valid) begin
      event_valid_i    = 1'b1;
      event_i.id       = s.id;
      event_i.prio     = s.prio;
      event_i.tail_chain = s.tail_chain;
      offered++;
      // full level seen now is the level at the sampling edge
      if (!queue_full_o) begin
        ts = 16'(cycle_cnt / `TRACE_TICK_DIV);
        exp_q.push_back({s.id, s.prio, 7'b0, s.tail_chain, ts});
        accepted++;
      end else begin
        saw_full = 1'b1;
        dropped++;
      end
    end
    @(negedge clk_i);
    event_valid_i = 1'b0;
    repeat (s.gap) @(negedge clk_i);
  endtask

  // undo the byte stuffing and compare against the oldest accepted event
  task automatic decode_frame();
    byte_t       payload[$];
    int          idx;
    int          code;
    int          j;
    logic [39:0] got;
    logic [39:0] exp;
    frames++;
    check_value("frame_len", rx_frame.size(), 6);
    idx = 0;
    while (idx < rx_frame.size()) begin
      code = rx_frame[idx];
      idx++;
      for (j = 1; j < code && idx < rx_frame.size(); j++) begin
        payload.push_back(rx_frame[idx]);
        idx++;
      end
      if (idx < rx_frame.size()) begin
        payload.push_back(8'h00);
      end
    end
    if (payload.size() != TRACE_PAYLOAD_BYTES) begin
      errors++;
      $display("frame decoded to %0d bytes instead of 5 at %0t", payload.size(), $time);
    end else if (exp_q.size() == 0) begin
      errors++;
      $display("frame received while no event was pending at %0t", $time);
    end else begin
      exp = exp_q.pop_front();
      got = {payload[0], payload[1], payload[2], payload[3], payload[4]};
      check_value("id", got[39:32], exp[39:32]);
      check_value("prio", got[31:24], exp[31:24]);
      check_value("flags", got[23:16], exp[23:16]);
      check_value("timestamp", got[15:0], exp[15:0]);
    end
  endtask

  // serial receiver sampling each bit near its middle on falling clock edges
  initial begin : receiver
    byte_t rx_byte;
    @(negedge reset_i);
    forever begin
      @(negedge tx_o);
      repeat (`TRACE_BAUD_DIV / 2) @(negedge clk_i);
      if (tx_o !== 1'b0) begin
        errors++;
        $display("start bit not low at mid-bit at %0t", $time);
      end else begin
        for (int b = 0; b < 8; b++) begin
          repeat (`TRACE_BAUD_DIV) @(negedge clk_i);
          rx_byte[b] = tx_o;
        end
        repeat (`TRACE_BAUD_DIV) @(negedge clk_i);
        if (tx_o !== 1'b1) begin
          errors++;
          $display("stop bit not high at %0t", $time);
        end
        rx_count++;
        if (rx_byte == 8'h00) begin
          decode_frame();
          rx_frame.delete();
        end else begin
          rx_frame.push_back(rx_byte);
        end
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout, trace frames did not drain, %0d still pending", exp_q.size());
    $display("Test failed");
    $finish;
  end

  initial begin : stimulus
    stim_t       s;
    logic [31:0] r;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    event_valid_i = 1'b0;
    event_i       = '0;
    checks        = 0;
    errors        = 0;
    frames        = 0;
    rx_count      = 0;
    offered       = 0;
    accepted      = 0;
    dropped       = 0;
    saw_full      = 1'b0;
    lcg_state     = 32'h7480_7912;

    // single events with zero fields and zero timestamp bytes
    stim_table[0] = make_entry(1'b1, 8'h3a, 8'h05, 1'b1, 1'b0, 300);
    stim_table[1] = make_entry(1'b1, 8'h00, 8'h07, 1'b0, 1'b0, 300);
    stim_table[2] = make_entry(1'b1, 8'h11, 8'h00, 1'b1, 1'b0, 300);
    stim_table[3] = make_entry(1'b1, 8'h00, 8'h00, 1'b0, 1'b1, 300);
    stim_table[4] = make_entry(1'b1, 8'hff, 8'h80, 1'b1, 1'b1, 300);
    stim_table[5] = make_entry(1'b0, 8'h00, 8'h00, 1'b0, 1'b0, 100);
    // back-to-back events filling the event queue
    for (int i = 0; i < `TRACE_EVT_DEPTH; i++) begin
      stim_table[6 + i] = make_entry(1'b1, 8'(8'h21 + i), 8'(8'h01 + i), 1'(i), 1'b0,
                                     (i == `TRACE_EVT_DEPTH - 1) ?
                                     `TRACE_EVT_DEPTH * frame_cycles + 100 : 0);
    end
    // burst that overruns the event queue
    for (int i = 0; i < 10; i++) begin
      stim_table[6 + `TRACE_EVT_DEPTH + i] =
        make_entry(1'b1, 8'(8'h40 + i), 8'(8'h10 + i), 1'(i), 1'b0, 0);
    end
    stim_table[table_len - 1] = make_entry(1'b0, 8'h00, 8'h00, 1'b0, 1'b0, 2000);

    repeat (3) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);
    check_value("tx_o", tx_o, 1);
    check_value("queue_full_o", queue_full_o, 0);
    repeat (50) @(negedge clk_i);
    check_value("rx_bytes_before_first_event", rx_count, 0);

    for (int i = 0; i < table_len; i++) begin
      apply_event(stim_table[i]);
      // the queue starts empty, so every event up to the back-to-back group fits
      if (i == 5 + `TRACE_EVT_DEPTH) begin
        check_value("accepted_before_burst", accepted, offered);
      end
    end
    for (int i = 0; i < rand_len; i++) begin
      r = lcg_next();
      s = make_entry(1'b1, r[31:24], r[23:16], r[15], 1'b0,
                     int'(r[5:0]) + (r[14] ? 150 : 0));
      apply_event(s);
    end

    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
    // idle window to catch any stray frame
    repeat (frame_cycles) @(negedge clk_i);
    check_value("queue_full_o_seen_high", saw_full, 1);

    $display("checks %0d, errors %0d, frames %0d, accepted %0d, dropped %0d",
             checks, errors, frames, accepted, dropped);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verification/irq_trace_props.sv */
// irq_trace_props: concurrent checks on the serial line and queue level of the trace top level
`timescale 1ns/1ps
`include "trace_params.svh"

module irq_trace_props (
  input logic clk_i,
  input logic reset_i,
  input logic tx_i,
  input logic queue_full_i
);

  // line idles high while held in reset
  idle_in_reset: assert property (
    @(posedge clk_i) reset_i && $past(reset_i) |-> tx_i
  ) else $error("tx_o not idle high during reset");

  // event queue comes out of reset empty
  full_clear_after_reset: assert property (
    @(posedge clk_i) $fell(reset_i) |-> !queue_full_i
  ) else $error("queue_full_o high in the first cycle after reset");

  // a start bit, or any low bit, lasts a full bit time
  low_bit_length: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $fell(tx_i) |-> (!tx_i) [*`TRACE_BAUD_DIV]
  ) else $error("tx_o low for less than one bit time");

  // same for high bits and the stop bit
  high_bit_length: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $rose(tx_i) |-> tx_i [*`TRACE_BAUD_DIV]
  ) else $error("tx_o high for less than one bit time");

endmodule

/* source/irq_trace_top.sv */
// irq_trace_top: interrupt trace path from event strobe to COBS-framed serial line
`timescale 1ns / 1ps
`include "trace_params.svh"

module irq_trace_top (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  event_valid_i,
    input  trace_pkg::irq_event_t event_i,
    output logic                  tx_o,
    output logic                  queue_full_o
);
  import trace_pkg::*;

  // capture
  timestamp_t now;
  trace_timestamp timestamp (
      .clk_i,
      .reset_i,
      .now_o(now)
  );

  trace_record_t rec_in;
  assign rec_in = {event_i, now};

  trace_record_t evt_head;
  logic evt_empty;
  logic evt_full;
  logic evt_pop;
  // writes while full are dropped inside the queue
  sync_fifo #(
      .T(trace_record_t),
      .DEPTH(`TRACE_EVT_DEPTH)
  ) evt_q (
      .clk_i,
      .reset_i,
      .push_i (event_valid_i),
      .data_i (rec_in),
      .pop_i  (evt_pop),
      .data_o (evt_head),
      .full_o (evt_full),
      .empty_o(evt_empty)
  );
  assign queue_full_o = evt_full;

  // framing
  byte_t enc_byte;
  logic enc_push;
  logic byte_full;
  cobs_frame_encoder encoder (
      .clk_i,
      .reset_i,
      .rec_empty_i(evt_empty),
      .rec_i      (evt_head),
      .rec_pop_o  (evt_pop),
      .byte_full_i(byte_full),
      .byte_push_o(enc_push),
      .byte_o     (enc_byte)
  );

  byte_t byte_head;
  logic byte_empty;
  logic uart_pop;
  sync_fifo #(
      .T(byte_t),
      .DEPTH(`TRACE_BYTE_DEPTH)
  ) byte_q (
      .clk_i,
      .reset_i,
      .push_i (enc_push),
      .data_i (enc_byte),
      .pop_i  (uart_pop),
      .data_o (byte_head),
      .full_o (byte_full),
      .empty_o(byte_empty)
  );

  // serial out
  uart_tx uart (
      .clk_i,
      .reset_i,
      .empty_i(byte_empty),
      .data_i (byte_head),
      .pop_o  (uart_pop),
      .tx_o
  );

endmodule

/* source/uart_tx.sv */
// uart_tx: 8N1 serial transmitter that pulls bytes from the byte queue when idle
`timescale 1ns / 1ps
`include "trace_params.svh"

module uart_tx (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             empty_i,
    input  trace_pkg::byte_t data_i,
    output logic             pop_o,
    output logic             tx_o
);
  localparam int BaudW = (`TRACE_BAUD_DIV > 1) ? $clog2(`TRACE_BAUD_DIV) : 1;

  logic             busy_q;
  logic [3:0]       bit_cnt_q;
  logic [BaudW-1:0] baud_cnt_q;
  // stop, data lsb first, start
  logic [9:0]       shift_q;
  logic             bit_end;

  assign pop_o   = !busy_q && !empty_i;
  assign bit_end = (baud_cnt_q == BaudW'(`TRACE_BAUD_DIV - 1));

  // line idles high between bytes
  assign tx_o = busy_q ? shift_q[0] : 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q     <= 1'b0;
      bit_cnt_q  <= '0;
      baud_cnt_q <= '0;
    end else if (!busy_q) begin
      if (!empty_i) begin
        busy_q     <= 1'b1;
        bit_cnt_q  <= '0;
        baud_cnt_q <= '0;
      end
    end else begin
      if (bit_end) begin
        baud_cnt_q <= '0;
        bit_cnt_q  <= bit_cnt_q + 4'd1;
        // stop bit done
        if (bit_cnt_q == 4'd9) begin
          busy_q <= 1'b0;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      shift_q <= {1'b1, data_i, 1'b0};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

endmodule

/* source/cobs_frame_encoder.sv */
// cobs_frame_encoder: turns each trace record into a COBS-stuffed five-byte frame plus delimiter
`timescale 1ns / 1ps

module cobs_frame_encoder (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     rec_empty_i,
    input  trace_pkg::trace_record_t rec_i,
    output logic                     rec_pop_o,
    input  logic                     byte_full_i,
    output logic                     byte_push_o,
    output trace_pkg::byte_t         byte_o
);
  import trace_pkg::*;

  localparam logic [2:0] LastIdx = 3'(TRACE_PAYLOAD_BYTES - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_CODE,
    ST_DATA,
    ST_DELIM
  } state_e;

  state_e state_q;
  logic [2:0] idx_q;

  trace_record_t rec_q;
  byte_t payload_q[TRACE_PAYLOAD_BYTES];
  logic [TRACE_PAYLOAD_BYTES-1:0] zero_q;
  logic [15:0] ts16;

  // code byte for a group starting at start, one plus the run of non-zero bytes
  function automatic byte_t code_at(input logic [TRACE_PAYLOAD_BYTES-1:0] mask,
                                    input logic [2:0] start);
    byte_t code;
    logic  found;
    code  = 8'd1;
    found = 1'b0;
    for (int i = 0; i < TRACE_PAYLOAD_BYTES; i++) begin
      if (i >= start && !found) begin
        if (mask[i]) begin
          found = 1'b1;
        end else begin
          code = code + 8'd1;
        end
      end
    end
    return code;
  endfunction

  assign ts16 = 16'(rec_q.ts);

  // head record is taken in the same cycle it is latched
  assign rec_pop_o = (state_q == ST_IDLE) && !rec_empty_i;

  assign byte_push_o = ((state_q == ST_CODE) || (state_q == ST_DATA) ||
                        (state_q == ST_DELIM)) && !byte_full_i;

  always_comb begin
    case (state_q)
      ST_CODE: byte_o = code_at(zero_q, 3'd0);
      // a zero in the payload is replaced by the next group's code
      ST_DATA: byte_o = zero_q[idx_q] ? code_at(zero_q, idx_q + 3'd1) : payload_q[idx_q];
      default: byte_o = 8'h00;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (!rec_empty_i) begin
            state_q <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          idx_q   <= '0;
          state_q <= ST_CODE;
        end
        ST_CODE: begin
          if (!byte_full_i) begin
            state_q <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (!byte_full_i) begin
            idx_q <= idx_q + 3'd1;
            if (idx_q == LastIdx) begin
              state_q <= ST_DELIM;
            end
          end
        end
        ST_DELIM: begin
          if (!byte_full_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // record capture and payload split
  always_ff @(posedge clk_i) begin
    if (rec_pop_o) begin
      rec_q <= rec_i;
    end
    if (state_q == ST_LOAD) begin
      payload_q[0] <= rec_q.evt.id;
      payload_q[1] <= rec_q.evt.prio;
      payload_q[2] <= {7'b0, rec_q.evt.tail_chain};
      payload_q[3] <= ts16[15:8];
      payload_q[4] <= ts16[7:0];
      zero_q[0]    <= (rec_q.evt.id == 8'h00);
      zero_q[1]    <= (rec_q.evt.prio == 8'h00);
      zero_q[2]    <= !rec_q.evt.tail_chain;
      zero_q[3]    <= (ts16[15:8] == 8'h00);
      zero_q[4]    <= (ts16[7:0] == 8'h00);
    end
  end

endmodule

/* source/trace_timestamp.sv */
// trace_timestamp: wrapping time base that advances once per prescale period
`timescale 1ns / 1ps
`include "trace_params.svh"

module trace_timestamp (
    input  logic                 clk_i,
    input  logic                 reset_i,
    output trace_pkg::timestamp_t now_o
);
  localparam int PreW = (`TRACE_TICK_DIV > 1) ? $clog2(`TRACE_TICK_DIV) : 1;

  logic [PreW-1:0] pre_q;
  logic            tick;

  // one tick at the end of every prescale period
  assign tick = (pre_q == PreW'(`TRACE_TICK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pre_q <= '0;
      now_o <= '0;
    end else begin
      if (tick) begin
        pre_q <= '0;
        // wraps at full width
        now_o <= now_o + 1'b1;
      end else begin
        pre_q <= pre_q + 1'b1;
      end
    end
  end

endmodule

/* source/sync_fifo.sv */
// sync_fifo: circular queue for any payload type with registered full and empty levels
`timescale 1ns / 1ps

module sync_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk_i,
    input  logic reset_i,
    input  logic push_i,
    input  T     data_i,
    input  logic pop_i,
    output T     data_o,
    output logic full_o,
    output logic empty_o
);
  localparam int PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CntW = $clog2(DEPTH + 1);

  T mem[DEPTH];

  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CntW-1:0] count_next;
  logic push_ok;
  logic pop_ok;

  function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // full queue drops pushes, empty queue drops pops
  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && !empty_o;

  always_comb begin
    count_next = count_q;
    if (push_ok && !pop_ok) begin
      count_next = count_q + 1'b1;
    end else if (pop_ok && !push_ok) begin
      count_next = count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_o   <= 1'b0;
      empty_o  <= 1'b1;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_next;
      full_o  <= (count_next == CntW'(DEPTH));
      empty_o <= (count_next == '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // head entry, valid whenever empty_o is low
  assign data_o = mem[rd_ptr_q];

endmodule

/* source/trace_pkg.sv */
// trace types shared by capture, framing and serial output
`include "trace_params.svh"

package trace_pkg;

  // one taken interrupt as reported by the core
  typedef struct packed {
    logic [7:0] id;
    logic [7:0] prio;
    logic       tail_chain;
  } irq_event_t;

  // free-running time base sampled at capture
  typedef logic [`TRACE_TS_WIDTH-1:0] timestamp_t;

  // queued event with its capture time
  typedef struct packed {
    irq_event_t evt;
    timestamp_t ts;
  } trace_record_t;

  typedef logic [7:0] byte_t;

  // payload is id, prio, flags, ts high, ts low
  localparam int TRACE_PAYLOAD_BYTES = 5;

endpackage

/* source/trace_params.svh */
// trace path parameters for queue depths, serial bit rate and timestamp base
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// timestamp counter width in bits
`define TRACE_TS_WIDTH 16

// clocks per timestamp tick
`define TRACE_TICK_DIV 2

// event record queue depth
`define TRACE_EVT_DEPTH 4

// serial byte queue depth
`define TRACE_BYTE_DEPTH 8

// clocks per serial bit
`define TRACE_BAUD_DIV 4

`endif
